//--- design/fault_pkg.sv
// fault class definitions for the core health monitor
// source counts per class and bit positions inside each fault vector
`default_nettype none

package fault_pkg;

	// --------------------
	// class widths
	localparam int LUT_SRC_W  = 8;   // lutram parity sources
	localparam int BRAM_SRC_W = 7;   // block ram parity sources
	localparam int ECC_SRC_W  = 2;   // corrected single-bit ecc

	// --------------------
	// lutram source bits, msb first
	localparam int LUT_SRC_FETCH    = 7;
	localparam int LUT_SRC_DECODE   = 6;
	localparam int LUT_SRC_EXEC     = 5;
	localparam int LUT_SRC_XC       = 4;
	localparam int LUT_SRC_IMEM_IF  = 3;
	localparam int LUT_SRC_DMEM_IF  = 2;
	localparam int LUT_SRC_DMA      = 1;
	localparam int LUT_SRC_DRAMCTRL = 0;

	// bram parity source bits
	localparam int BRAM_SRC_DECODE    = 6;
	localparam int BRAM_SRC_EXEC      = 5;
	localparam int BRAM_SRC_XC        = 4;
	localparam int BRAM_SRC_ITLB_TAG  = 3;
	localparam int BRAM_SRC_ITLB_DATA = 2;
	localparam int BRAM_SRC_DTLB_TAG  = 1;
	localparam int BRAM_SRC_DTLB_DATA = 0;

	// ecc sources
	localparam int ECC_SRC_DECODE = 1;
	localparam int ECC_SRC_XC     = 0;

endpackage

`default_nettype wire

//--- design/trace_pkg.sv
// flight recorder definitions
// trace record layout plus fifo depth, read lag and end-to-end delay
`default_nettype none

package trace_pkg;

	// --------------------
	// one committed instruction, 104 bits
	typedef struct packed {
		logic [31:0] inst;      // instruction word
		logic [31:0] ex_res;    // execute result
		logic [29:0] pc;        // word pc
		logic [5:0]  tid;       // thread id
		logic        annul;
		logic        replay;
		logic        icmiss;    // icache miss on fetch
		logic        dma_mode;
	} trace_record_t;

	// --------------------
	// recorder sizing
	localparam int FR_DEPTH = 32;          // records held in fifo
	localparam int FR_LAG   = 24;          // fill that starts reading

	// trace_in to trace_out, in cycles
	// one cycle to latch read start, one for the output register
	localparam int FR_DELAY = FR_LAG + 2;

endpackage

`default_nettype wire

//--- design/sticky_fault_flag.sv
// sticky fault flag for one fault class
// registers the per-cycle strobes, ors them down and holds the result
// until reset; strobe to flag is 2 cycles
`timescale 1ns/1ns
`default_nettype none

module sticky_fault_flag #(
	parameter int WIDTH = fault_pkg::LUT_SRC_W
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [WIDTH-1:0] err,     // per-cycle strobes
	output logic             flag     // sticky, any source seen
);

	logic [WIDTH-1:0] err_r;   // first stage, captured strobes

	// --------------------
	// capture, then reduce and hold
	always_ff @(posedge clk) begin
		if (rst) begin
			err_r <= '0;
			flag  <= 1'b0;
		end
		else begin
			err_r <= err;   // single-cycle pulses land here
			// once set, only reset clears it
			flag  <= flag | (|err_r);
		end
	end

endmodule

`default_nettype wire

//--- design/trace_fifo.sv
// synchronous fifo for flight recorder trace records
// circular buffer with fill count, registered read data and a flag
// that is high while the fill is at or above the read lag
`timescale 1ns/1ns
`default_nettype none

module trace_fifo #(
	parameter int DEPTH = trace_pkg::FR_DEPTH
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     wr_en,
	input  trace_pkg::trace_record_t wr_data,
	input  logic                     rd_en,
	output trace_pkg::trace_record_t rd_data,     // valid the cycle after a read
	output logic                     lag_reached
);

	import trace_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // pointer width
	localparam int CW = $clog2(DEPTH + 1);                 // count reaches DEPTH

	trace_record_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;      // current fill
	logic          full;
	logic          empty;
	logic          do_wr;
	logic          do_rd;

	// --------------------
	// status and qualified strobes
	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign do_rd = rd_en & ~empty;
	assign do_wr = wr_en & (~full | do_rd);   // a read frees one slot this cycle

	assign lag_reached = (count >= CW'(FR_LAG));

	// --------------------
	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr];   // output register
	end

	// --------------------
	// pointers and fill count
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // idle, or write and read together
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/flight_recorder.sv
// flight recorder for committed instructions
// writes a record every cycle out of reset; once the fifo holds FR_LAG
// records it reads every cycle too, so trace_out is trace_in FR_DELAY
// cycles late
`timescale 1ns/1ns
`default_nettype none

module flight_recorder (
	input  logic                     clk,
	input  logic                     rst,
	input  trace_pkg::trace_record_t trace_in,
	output trace_pkg::trace_record_t trace_out,
	output logic                     trace_valid   // high from first read data on
);

	import trace_pkg::*;

	logic start_read;    // sticky, reading has begun
	logic lag_reached;
	logic wr_en;

	assign wr_en = ~rst;   // record on every cycle outside reset

	// --------------------
	// read start and output valid
	always_ff @(posedge clk) begin
		if (rst) begin
			start_read  <= 1'b0;
			trace_valid <= 1'b0;
		end
		else begin
			start_read  <= start_read | lag_reached;   // latch, hold until reset
			trace_valid <= start_read;                 // matches fifo read latency
		end
	end

	// --------------------
	// record buffer
	trace_fifo #(
		.DEPTH(FR_DEPTH)
	) u_fifo (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (wr_en),
		.wr_data    (trace_in),
		.rd_en      (start_read),   // no back-pressure, fill stays constant
		.rd_data    (trace_out),
		.lag_reached(lag_reached)
	);

endmodule

`default_nettype wire

//--- design/core_monitor_top.sv
// core health monitor top
// sticky flags for lutram, bram and ecc faults and for pipeline error
// mode, the two board leds, and the instruction flight recorder
`timescale 1ns/1ns
`default_nettype none

module core_monitor_top (
	input  logic                             clk,
	input  logic                             rst,
	// fault strobes
	input  logic [fault_pkg::LUT_SRC_W-1:0]  lut_err,
	input  logic [fault_pkg::BRAM_SRC_W-1:0] bram_err,
	input  logic [fault_pkg::ECC_SRC_W-1:0]  ecc_err,
	input  logic                             xc_error_mode,   // level from exception stage
	// sticky flags and leds
	output logic                             luterr,
	output logic                             bramerr,
	output logic                             sb_ecc,
	output logic                             error1_led,
	output logic                             error2_led,
	// trace
	input  trace_pkg::trace_record_t         trace_in,
	output trace_pkg::trace_record_t         trace_out,
	output logic                             trace_valid
);

	import fault_pkg::*;

	// --------------------
	// fault classes
	sticky_fault_flag #(.WIDTH(LUT_SRC_W)) u_lut_flag (
		.clk (clk),
		.rst (rst),
		.err (lut_err),
		.flag(luterr)
	);

	sticky_fault_flag #(.WIDTH(BRAM_SRC_W)) u_bram_flag (
		.clk (clk),
		.rst (rst),
		.err (bram_err),
		.flag(bramerr)
	);

	sticky_fault_flag #(.WIDTH(ECC_SRC_W)) u_ecc_flag (
		.clk (clk),
		.rst (rst),
		.err (ecc_err),
		.flag(sb_ecc)
	);

	// error mode is a single level, same 2-cycle sticky path
	sticky_fault_flag #(.WIDTH(1)) u_xc_flag (
		.clk (clk),
		.rst (rst),
		.err (xc_error_mode),
		.flag(error1_led)
	);

	// any seu class seen
	assign error2_led = luterr | bramerr | sb_ecc;

	// --------------------
	// flight recorder
	flight_recorder u_recorder (
		.clk        (clk),
		.rst        (rst),
		.trace_in   (trace_in),
		.trace_out  (trace_out),
		.trace_valid(trace_valid)
	);

endmodule

`default_nettype wire

//--- sim/core_monitor_props.sv
// concurrent checks for the core health monitor
// sticky flags and trace_valid only fall after a reset edge, and the
// recorder fifo never fills up, so no record is ever refused
`timescale 1ns/1ns
`default_nettype none

module core_monitor_props (
	input logic                                       clk,
	input logic                                       rst,
	input logic                                       luterr,
	input logic                                       bramerr,
	input logic                                       sb_ecc,
	input logic                                       error1_led,
	input logic                                       trace_valid,
	input logic [$clog2(trace_pkg::FR_DEPTH + 1)-1:0] fill   // fifo count
);

	import trace_pkg::*;

	int unsigned assert_errors = 0;   // failures seen so far

	// --------------------
	// sticky flags
	a_luterr_hold: assert property (@(posedge clk) $fell(luterr) |-> $past(rst))
		else begin
			$error("luterr fell while rst was low");
			assert_errors++;
		end

	a_bramerr_hold: assert property (@(posedge clk) $fell(bramerr) |-> $past(rst))
		else begin
			$error("bramerr fell while rst was low");
			assert_errors++;
		end

	a_sb_ecc_hold: assert property (@(posedge clk) $fell(sb_ecc) |-> $past(rst))
		else begin
			$error("sb_ecc fell while rst was low");
			assert_errors++;
		end

	a_error1_hold: assert property (@(posedge clk) $fell(error1_led) |-> $past(rst))
		else begin
			$error("error1_led fell while rst was low");
			assert_errors++;
		end

	// --------------------
	// recorder
	a_valid_hold: assert property (@(posedge clk) $fell(trace_valid) |-> $past(rst))
		else begin
			$error("trace_valid fell while rst was low");
			assert_errors++;
		end

	// reading starts at the lag, so the fill must stay short of full
	a_fill_bound: assert property (@(posedge clk) disable iff (rst) fill < FR_DEPTH)
		else begin
			$error("fifo fill reached its depth");
			assert_errors++;
		end

endmodule

bind core_monitor_top core_monitor_props u_props (
	.clk        (clk),
	.rst        (rst),
	.luterr     (luterr),
	.bramerr    (bramerr),
	.sb_ecc     (sb_ecc),
	.error1_led (error1_led),
	.trace_valid(trace_valid),
	.fill       (u_recorder.u_fifo.count)
);

`default_nettype wire

//--- sim/core_monitor_tb.sv
// testbench for the core health monitor
// random fault strobes and trace records from an xorshift source, checked
// every cycle against a model of the sticky flags and the recorder delay
`timescale 1ns/1ns
`default_nettype none

module core_monitor_tb;

	import fault_pkg::*;
	import trace_pkg::*;

	// --------------------
	// run length
	localparam int RST_CYCLES     = 16;
	localparam int MID_RST_CYCLES = 5;
	localparam int PHASE_CYCLES   = 1000;
	localparam int QUIET_CYCLES   = 150;    // faults held at zero at phase start
	// resets and two phases come to about 2020 cycles, rest is margin
	localparam int MAX_CYCLES     = 2400;

	localparam logic [9:0] MASK_PHASE1 = 10'h1ff;   // about 1 in 512 per bit
	localparam logic [9:0] MASK_PHASE2 = 10'h3ff;   // sparser, 1 in 1024

	// --------------------
	// dut signals
	logic                  clk;
	logic                  rst;
	logic [LUT_SRC_W-1:0]  lut_err;
	logic [BRAM_SRC_W-1:0] bram_err;
	logic [ECC_SRC_W-1:0]  ecc_err;
	logic                  xc_error_mode;
	logic                  luterr;
	logic                  bramerr;
	logic                  sb_ecc;
	logic                  error1_led;
	logic                  error2_led;
	trace_record_t         trace_in;
	trace_record_t         trace_out;
	logic                  trace_valid;

	// --------------------
	// bookkeeping
	logic [31:0]   rng;            // xorshift state
	int unsigned   cycle;
	int            fault_errors;
	int            trace_errors;
	int            total_errors;

	// reference model
	logic [1:0]    lut_hist;       // any bit set per edge, newest in bit 0
	logic [1:0]    bram_hist;
	logic [1:0]    ecc_hist;
	logic [1:0]    xc_hist;
	logic          exp_luterr;
	logic          exp_bramerr;
	logic          exp_sb_ecc;
	logic          exp_error1;
	int            since_rel;      // edges since reset went low
	logic          valid_prev;
	trace_record_t trace_hist[$];  // records taken by the recorder, oldest first

	core_monitor_top u_core_monitor_top (
		.clk          (clk),
		.rst          (rst),
		.lut_err      (lut_err),
		.bram_err     (bram_err),
		.ecc_err      (ecc_err),
		.xc_error_mode(xc_error_mode),
		.luterr       (luterr),
		.bramerr      (bramerr),
		.sb_ecc       (sb_ecc),
		.error1_led   (error1_led),
		.error2_led   (error2_led),
		.trace_in     (trace_in),
		.trace_out    (trace_out),
		.trace_valid  (trace_valid)
	);

	// --------------------
	// clock and timeout
	initial clk = 1'b0;
	always #4 clk = ~clk;   // 8 ns

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Error: timeout, the run was still going after %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------
	// helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_mismatch(input string name, input logic [127:0] exp_val,
		input logic [127:0] got_val, input logic trace_side);
		$display("Fail %s at cycle %0d expected 0x%0h got 0x%0h", name, cycle, exp_val, got_val);
		if (trace_side)
			trace_errors++;
		else
			fault_errors++;
	endtask

	// model update for the edge just taken, inputs still hold what it sampled
	task automatic step_model();
		if (rst) begin
			lut_hist    = '0;
			bram_hist   = '0;
			ecc_hist    = '0;
			xc_hist     = '0;
			exp_luterr  = 1'b0;
			exp_bramerr = 1'b0;
			exp_sb_ecc  = 1'b0;
			exp_error1  = 1'b0;
			since_rel   = 0;
			trace_hist.delete();   // fifo empties on reset
		end
		else begin
			lut_hist    = {lut_hist[0], |lut_err};
			bram_hist   = {bram_hist[0], |bram_err};
			ecc_hist    = {ecc_hist[0], |ecc_err};
			xc_hist     = {xc_hist[0], xc_error_mode};
			// flag shows the edge after the one that sampled the strobe
			exp_luterr  = exp_luterr | lut_hist[1];
			exp_bramerr = exp_bramerr | bram_hist[1];
			exp_sb_ecc  = exp_sb_ecc | ecc_hist[1];
			exp_error1  = exp_error1 | xc_hist[1];
			since_rel++;
			trace_hist.push_back(trace_in);
			if (trace_hist.size() > FR_DELAY)
				void'(trace_hist.pop_front());
		end
	endtask

	task automatic check_outputs();
		// fault flags and leds
		if (luterr !== exp_luterr)
			report_mismatch("luterr", 128'(exp_luterr), 128'(luterr), 1'b0);
		if (bramerr !== exp_bramerr)
			report_mismatch("bramerr", 128'(exp_bramerr), 128'(bramerr), 1'b0);
		if (sb_ecc !== exp_sb_ecc)
			report_mismatch("sb_ecc", 128'(exp_sb_ecc), 128'(sb_ecc), 1'b0);
		if (error1_led !== exp_error1)
			report_mismatch("error1_led", 128'(exp_error1), 128'(error1_led), 1'b0);
		if (error2_led !== (exp_luterr | exp_bramerr | exp_sb_ecc))
			report_mismatch("error2_led", 128'(exp_luterr | exp_bramerr | exp_sb_ecc),
				128'(error2_led), 1'b0);

		// recorder valid window
		if (since_rel <= FR_LAG && trace_valid !== 1'b0)
			report_mismatch("trace_valid", 128'(1'b0), 128'(trace_valid), 1'b1);
		if (since_rel >= FR_DELAY && trace_valid !== 1'b1)
			report_mismatch("trace_valid", 128'(1'b1), 128'(trace_valid), 1'b1);
		if (valid_prev && !trace_valid && since_rel != 0) begin
			$display("Error: trace_valid dropped at cycle %0d with no reset", cycle);
			trace_errors++;
		end

		// recorder data, fixed lag behind trace_in
		if (since_rel >= FR_DELAY && trace_hist.size() == FR_DELAY) begin
			if (trace_out !== trace_hist[0])
				report_mismatch("trace_out", 128'(trace_hist[0]), 128'(trace_out), 1'b1);
		end
		valid_prev = trace_valid;
	endtask

	task automatic drive_inputs(input logic rst_val, input logic quiet,
		input logic [9:0] mask);
		logic [31:0] w [4];
		rst = rst_val;
		for (int i = 0; i < LUT_SRC_W; i++) begin
			rng = xorshift32(rng);
			lut_err[i] = !quiet && ((rng[9:0] & mask) == 10'd0);
		end
		for (int i = 0; i < BRAM_SRC_W; i++) begin
			rng = xorshift32(rng);
			bram_err[i] = !quiet && ((rng[9:0] & mask) == 10'd0);
		end
		for (int i = 0; i < ECC_SRC_W; i++) begin
			rng = xorshift32(rng);
			ecc_err[i] = !quiet && ((rng[9:0] & mask) == 10'd0);
		end
		rng = xorshift32(rng);
		xc_error_mode = !quiet && ((rng[9:0] & mask) == 10'd0);
		// fresh 104-bit record every cycle
		for (int k = 0; k < 4; k++) begin
			rng  = xorshift32(rng);
			w[k] = rng;
		end
		trace_in = {w[0], w[1], w[2], w[3][7:0]};
	endtask

	task automatic run_cycles(input int n, input logic rst_val, input logic quiet,
		input logic [9:0] mask);
		repeat (n) begin
			@(negedge clk);
			step_model();
			check_outputs();
			drive_inputs(rst_val, quiet, mask);
		end
	endtask

	// --------------------
	// test sequence
	initial begin
		rst           = 1'b1;
		lut_err       = '0;
		bram_err      = '0;
		ecc_err       = '0;
		xc_error_mode = 1'b0;
		trace_in      = '0;
		rng           = 32'h3246;
		cycle         = 0;
		fault_errors  = 0;
		trace_errors  = 0;
		lut_hist      = '0;
		bram_hist     = '0;
		ecc_hist      = '0;
		xc_hist       = '0;
		exp_luterr    = 1'b0;
		exp_bramerr   = 1'b0;
		exp_sb_ecc    = 1'b0;
		exp_error1    = 1'b0;
		since_rel     = 0;
		valid_prev    = 1'b0;

		// power-on reset, rst already high for the first edge
		run_cycles(RST_CYCLES - 1, 1'b1, 1'b1, MASK_PHASE1);

		// phase 1, quiet start then random faults
		run_cycles(QUIET_CYCLES, 1'b0, 1'b1, MASK_PHASE1);
		run_cycles(PHASE_CYCLES - QUIET_CYCLES, 1'b0, 1'b0, MASK_PHASE1);

		// mid-run reset while strobes keep arriving
		run_cycles(MID_RST_CYCLES, 1'b1, 1'b0, MASK_PHASE1);

		// phase 2, sparser faults
		run_cycles(QUIET_CYCLES, 1'b0, 1'b1, MASK_PHASE2);
		run_cycles(PHASE_CYCLES - QUIET_CYCLES, 1'b0, 1'b0, MASK_PHASE2);

		@(negedge clk);   // last driven cycle
		step_model();
		check_outputs();

		total_errors = fault_errors + trace_errors +
			int'(u_core_monitor_top.u_props.assert_errors);
		$display("errors: %0d total, %0d fault path, %0d trace path, %0d assertion",
			total_errors, fault_errors, trace_errors, u_core_monitor_top.u_props.assert_errors);
		if (total_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
design/fault_pkg.sv
design/trace_pkg.sv
design/sticky_fault_flag.sv
design/trace_fifo.sv
design/flight_recorder.sv
design/core_monitor_top.sv
sim/core_monitor_props.sv
sim/core_monitor_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the core health monitor

TOP := core_monitor_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f design/*.sv sim/*.sv
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

# the run fails unless the pass line shows up in the output
run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Simulation passed'

lint:
	verilator --lint-only -Wall --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
